// File: Bender.yml
package:
  name: floo_red

sources:
  - include_dirs:
      - include
    files:
      - source/floo_red_pkg.sv
      - source/floo_wormhole_arbiter.sv
      - source/floo_reduction_arbiter.sv
      - source/floo_output_arbiter.sv
      - source/floo_out_spill.sv
      - source/floo_red_out_port.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/floo_red_checker.sv
      - sim/floo_red_tb.sv

// File: flist.f
+incdir+include
source/floo_red_pkg.sv
source/floo_wormhole_arbiter.sv
source/floo_reduction_arbiter.sv
source/floo_output_arbiter.sv
source/floo_out_spill.sv
source/floo_red_out_port.sv
sim/floo_red_checker.sv
sim/floo_red_tb.sv

// File: include/floo_red_consts.svh
// Global sizes for the reduction port; FLOO_MASK_W must track FLOO_NUM_ROUTES.
`ifndef FLOO_RED_CONSTS_SVH
`define FLOO_RED_CONSTS_SVH

// Number of input routes that compete for the output port.
`define FLOO_NUM_ROUTES 4

// Width of a node identifier in the flit header.
`define FLOO_ID_W 4

// Width of the flit payload and of the reduction datapath.
`define FLOO_DATA_W 32

// One bit per input route names the operands of a reduction.
`define FLOO_MASK_W `FLOO_NUM_ROUTES

`endif

// File: sim/floo_red_checker.sv
// Port assertions; opcode agreement is only checked once every operand of a reduction is present.
`include "floo_red_consts.svh"

module floo_red_checker (
  input logic                                         clk_i,
  input logic                                         rst_n_i,
  input logic                [`FLOO_NUM_ROUTES-1:0]   in_valid_i,
  input logic                [`FLOO_NUM_ROUTES-1:0]   in_ready_i,
  input floo_red_pkg::flit_t [`FLOO_NUM_ROUTES-1:0]   in_data_i,
  input floo_red_pkg::wh_state_e                      wh_state_i,
  input logic                                         out_valid_i,
  input logic                                         out_ready_i,
  input floo_red_pkg::flit_t                          out_data_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;
  logic        ops_agree;

  // The lowest reducing route leads, as in the reduction arbiter.
  always_comb begin
    floo_red_pkg::flit_t lead;
    logic found;
    logic complete;
    logic same;
    lead = '0;
    found = 1'b0;
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (!found && in_valid_i[i] && in_data_i[i].reduce) begin
        lead = in_data_i[i];
        found = 1'b1;
      end
    end
    complete = found;
    same = 1'b1;
    for (int i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      if (lead.red_mask[i]) begin
        complete = complete & in_valid_i[i] & in_data_i[i].reduce;
        same = same & (in_data_i[i].red_op == lead.red_op);
      end
    end
    ops_agree = !complete || same;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
    else begin
      fail_count++;
      $error("Output flit was not held under back-pressure.");
    end

  assert property (@(posedge clk_i) $rose(rst_n_i) |->
    !out_valid_i && (in_ready_i == '0) && (wh_state_i == floo_red_pkg::WH_IDLE))
    else begin
      fail_count++;
      $error("Port was not idle in the first cycle after reset.");
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) ops_agree)
    else begin
      fail_count++;
      $error("Operands of one reduction carry different opcodes.");
    end

endmodule

bind floo_red_out_port floo_red_checker u_checker (
  .clk_i       ( clk_i                                      ),
  .rst_n_i     ( rst_n_i                                    ),
  .in_valid_i  ( valid_i                                    ),
  .in_ready_i  ( ready_o                                    ),
  .in_data_i   ( data_i                                     ),
  .wh_state_i  ( u_output_arbiter.u_wormhole_arbiter.state_q ),
  .out_valid_i ( valid_o                                    ),
  .out_ready_i ( ready_i                                    ),
  .out_data_i  ( data_o                                     )
);

// File: sim/floo_red_tb.sv
// Self-checking testbench; each reduction includes route 0, so reductions leave in generation order.
`include "floo_red_consts.svh"

module floo_red_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NR = `FLOO_NUM_ROUTES;
  localparam int IdW = `FLOO_ID_W;
  localparam logic [IdW-1:0] NODE_ID = IdW'(10);
  localparam int T2_PKTS = 16;
  localparam int T3_LEN = 3;
  localparam int T6_ITEMS = 40;
  // Upper bound on input flits, counting NR flits for every reduction.
  localparam int TOTAL_FLITS = T2_PKTS + 4 * NR * T3_LEN + 8 * NR + 4 + NR * T6_ITEMS;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_FLITS + 200;

  logic                         clk;
  logic                         rst_n;
  logic [NR-1:0]                in_valid;
  logic [NR-1:0]                in_ready;
  floo_red_pkg::flit_t [NR-1:0] in_data;
  logic [IdW-1:0]               node_id;
  logic                         out_valid;
  logic                         out_ready;
  floo_red_pkg::flit_t          out_data;

  // Flits waiting to be offered per route, and the flits expected at the output.
  floo_red_pkg::flit_t src_q[NR][$];
  floo_red_pkg::flit_t exp_q[NR][$];
  floo_red_pkg::flit_t red_exp_q[$];

  logic [31:0]   rng_state = 32'd78595;
  logic [31:0]   ready_rand;
  logic [NR-1:0] fire = '0;
  logic          rand_ready = 1'b0;
  logic          check_lat = 1'b0;
  logic          lat_armed = 1'b0;
  logic          red_first = 1'b0;
  int            open_route = -1;
  int            cycle_cnt = 0;
  int            checks = 0;
  int            errors = 0;
  int            test_errors = 0;
  string         test_name = "";

  floo_red_out_port u_dut (
    .clk_i     ( clk       ),
    .rst_n_i   ( rst_n     ),
    .valid_i   ( in_valid  ),
    .ready_o   ( in_ready  ),
    .data_i    ( in_data   ),
    .node_id_i ( node_id   ),
    .valid_o   ( out_valid ),
    .ready_i   ( out_ready ),
    .data_o    ( out_data  )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_flit(input string name, input floo_red_pkg::flit_t exp,
                            input floo_red_pkg::flit_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %b actual %b", name, exp, act);
    end
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = (red_exp_q.size() == 0);
    for (int i = 0; i < NR; i++) begin
      empty = empty && (exp_q[i].size() == 0);
    end
    return empty;
  endfunction

  task automatic add_normal(input int route, input int len);
    floo_red_pkg::flit_t f;
    logic [31:0] r;
    r = next_rand();
    for (int i = 0; i < len; i++) begin
      f = '{last: (i == len - 1), reduce: 1'b0, red_op: floo_red_pkg::RED_ADD, red_mask: '0,
            src_id: IdW'(route), dst_id: r[IdW-1:0], payload: next_rand()};
      src_q[route].push_back(f);
      exp_q[route].push_back(f);
    end
  endtask

  // Offers one operand on every route of the mask and records the combined flit.
  // Operands carry different destinations; the lowest route of the mask leads.
  task automatic add_reduction(input floo_red_pkg::red_op_e op, input logic [NR-1:0] mask);
    floo_red_pkg::flit_t f;
    floo_red_pkg::flit_t res;
    logic [31:0] r;
    logic first;
    r = next_rand();
    first = 1'b1;
    res = '{last: 1'b1, reduce: 1'b0, red_op: op, red_mask: '0, src_id: NODE_ID,
            dst_id: '0, payload: '0};
    for (int i = 0; i < NR; i++) begin
      if (mask[i]) begin
        f = '{last: 1'b1, reduce: 1'b1, red_op: op, red_mask: mask, src_id: IdW'(i),
              dst_id: r[IdW*i +: IdW], payload: next_rand()};
        src_q[i].push_back(f);
        if (first) begin
          res.dst_id = f.dst_id;
        end
        case (op)
          floo_red_pkg::RED_ADD: res.payload = res.payload + f.payload;
          floo_red_pkg::RED_MAX: res.payload = (f.payload > res.payload) ? f.payload : res.payload;
          floo_red_pkg::RED_AND: res.payload = first ? f.payload : (res.payload & f.payload);
          floo_red_pkg::RED_OR:  res.payload = res.payload | f.payload;
        endcase
        first = 1'b0;
      end
    end
    red_exp_q.push_back(res);
  endtask

  // Reduced flits carry the node id as source, all others name their input route.
  task automatic check_output(input floo_red_pkg::flit_t f);
    int route;
    route = f.src_id;
    if (red_first) begin
      check_valid({test_name, " reduced first"}, 1'b1, f.src_id == NODE_ID);
      red_first = 1'b0;
    end
    if (f.src_id == NODE_ID && red_exp_q.size() != 0) begin
      check_flit({test_name, " reduced"}, red_exp_q.pop_front(), f);
    end else if (route >= NR || exp_q[route].size() == 0) begin
      errors++;
      $display("Error in %s: output flit from source %0d was never sent", test_name, route);
    end else begin
      if (open_route >= 0) begin
        check_valid({test_name, " no interleave"}, 1'b1, route == open_route);
      end
      open_route = f.last ? -1 : route;
      check_flit({test_name, " normal"}, exp_q[route].pop_front(), f);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = errors;
    open_route = -1;
  endtask

  // Once every expected flit has left, nothing else may follow at the output.
  task automatic end_test();
    while (!queues_empty()) begin
      @(posedge clk);
    end
    @(negedge clk);
    check_valid({test_name, " drained"}, 1'b0, out_valid);
    $display("Test %s %s with %0d errors", test_name,
             (errors == test_errors) ? "passed" : "failed", errors - test_errors);
  endtask

  // Offers the head of each route queue and drops the flits that the DUT has taken.
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < NR; i++) begin
        if (fire[i]) begin
          void'(src_q[i].pop_front());
        end
        in_valid[i] <= (src_q[i].size() != 0);
        if (src_q[i].size() != 0) begin
          in_data[i] <= src_q[i][0];
        end
      end
      ready_rand = next_rand();
      out_ready <= rand_ready ? ready_rand[7] : 1'b1;
    end
  end

  // Handshakes are sampled mid-cycle, where inputs and outputs are settled.
  always @(negedge clk) begin
    if (rst_n) begin
      fire = in_valid & in_ready;
      if (lat_armed) begin
        check_valid({test_name, " latency"}, 1'b1, out_valid);
        lat_armed = 1'b0;
      end
      if (check_lat && fire[0]) begin
        lat_armed = 1'b1;
      end
      if (out_valid && out_ready) begin
        check_output(out_data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped delivering flits", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] stim;
    rst_n = 1'b0;
    in_valid = '0;
    in_data = '0;
    out_ready = 1'b1;
    node_id = NODE_ID;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    start_test("reset_idle");
    check_valid("reset_idle valid_o", 1'b0, out_valid);
    end_test();

    start_test("single_route");
    check_lat = 1'b1;
    for (int i = 0; i < T2_PKTS; i++) begin
      add_normal(0, 1);
    end
    end_test();
    check_lat = 1'b0;

    start_test("wormhole");
    for (int p = 0; p < 4; p++) begin
      for (int route = 0; route < NR; route++) begin
        add_normal(route, T3_LEN);
      end
    end
    end_test();

    start_test("reduce_ops");
    for (int k = 0; k < 4; k++) begin
      stim = next_rand();
      add_reduction(floo_red_pkg::red_op_e'(k), '1);
      add_reduction(floo_red_pkg::red_op_e'(k), stim[NR-1:0] | NR'(1));
    end
    end_test();

    start_test("reduce_first");
    red_first = 1'b1;
    add_reduction(floo_red_pkg::RED_ADD, NR'(3));
    add_normal(2, 1);
    add_normal(3, 1);
    end_test();

    start_test("mixed_backpressure");
    rand_ready = 1'b1;
    for (int i = 0; i < T6_ITEMS; i++) begin
      stim = next_rand();
      if (stim[1:0] == 2'd0) begin
        add_reduction(floo_red_pkg::red_op_e'(stim[3:2]), stim[4 +: NR] | NR'(1));
      end else begin
        add_normal(int'(stim[15:8]) % NR, 1 + int'(stim[23:16]) % 3);
      end
    end
    end_test();
    rand_ready = 1'b0;

    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_dut.u_checker.fail_count);
    if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: source/floo_out_spill.sv
// Two-entry output stage with one cycle of latency; ready_o is registered and low in reset.
module floo_out_spill (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  floo_red_pkg::flit_t  data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output floo_red_pkg::flit_t  data_o
);

  logic                main_valid_q, main_valid_d;
  logic                skid_valid_q, skid_valid_d;
  logic                ready_q;
  floo_red_pkg::flit_t main_data_q, skid_data_q;
  logic                in_xfer;
  logic                main_free;

  assign in_xfer   = valid_i & ready_q;
  // The main entry can be refilled when it is empty or leaves this cycle.
  assign main_free = ~main_valid_q | ready_i;

  // A skid entry blocks the input, so the skid and a new flit never compete for main.
  always_comb begin
    main_valid_d = main_valid_q;
    skid_valid_d = skid_valid_q;
    if (main_free) begin
      main_valid_d = skid_valid_q | in_xfer;
      skid_valid_d = 1'b0;
    end else if (in_xfer) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      main_valid_q <= main_valid_d;
      skid_valid_q <= skid_valid_d;
      ready_q      <= ~skid_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (main_free && (skid_valid_q || in_xfer)) begin
      main_data_q <= skid_valid_q ? skid_data_q : data_i;
    end
    if (!main_free && in_xfer) begin
      skid_data_q <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

endmodule

// File: source/floo_output_arbiter.sv
// Reduced flits preempt normal traffic, even between flits of a locked wormhole packet.
`include "floo_red_consts.svh"

module floo_output_arbiter (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic                                  [`FLOO_NUM_ROUTES-1:0]  valid_i,
  output logic                                  [`FLOO_NUM_ROUTES-1:0]  ready_o,
  input  floo_red_pkg::flit_t                   [`FLOO_NUM_ROUTES-1:0]  data_i,
  input  logic                 [`FLOO_ID_W-1:0]                         node_id_i,
  output logic                                                          valid_o,
  input  logic                                                          ready_i,
  output floo_red_pkg::flit_t                                           data_o
);

  logic [`FLOO_NUM_ROUTES-1:0] is_red;
  logic [`FLOO_NUM_ROUTES-1:0] red_valid, red_ready;
  logic [`FLOO_NUM_ROUTES-1:0] norm_valid, norm_ready;

  floo_red_pkg::flit_t red_out_data, norm_out_data;
  logic                red_out_valid, norm_out_valid;
  logic                norm_out_ready;

  // The reduce bit of each offered flit picks its path.
  always_comb begin
    for (int unsigned i = 0; i < `FLOO_NUM_ROUTES; i++) begin
      is_red[i] = data_i[i].reduce;
    end
  end

  assign red_valid  = valid_i & is_red;
  assign norm_valid = valid_i & ~is_red;

  // The normal side only sees ready when no reduced flit claims the output.
  assign norm_out_ready = ready_i & ~red_out_valid;

  floo_wormhole_arbiter #(
    .NumRoutes ( `FLOO_NUM_ROUTES )
  ) u_wormhole_arbiter (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .valid_i ( norm_valid     ),
    .ready_o ( norm_ready     ),
    .data_i  ( data_i         ),
    .valid_o ( norm_out_valid ),
    .ready_i ( norm_out_ready ),
    .data_o  ( norm_out_data  )
  );

  floo_reduction_arbiter #(
    .NumRoutes ( `FLOO_NUM_ROUTES )
  ) u_reduction_arbiter (
    .valid_i   ( red_valid     ),
    .ready_o   ( red_ready     ),
    .data_i    ( data_i        ),
    .node_id_i ( node_id_i     ),
    .valid_o   ( red_out_valid ),
    .ready_i   ( ready_i       ),
    .data_o    ( red_out_data  )
  );

  assign valid_o = red_out_valid | norm_out_valid;
  assign data_o  = red_out_valid ? red_out_data : norm_out_data;

  // Each route takes the ready of the path its flit belongs to.
  assign ready_o = (is_red & red_ready) | (~is_red & norm_ready);

endmodule

// File: source/floo_red_out_port.sv
// Output port top; node_id_i is expected to stay static while traffic flows.
`include "floo_red_consts.svh"

module floo_red_out_port (
  input  logic                                                          clk_i,
  input  logic                                                          rst_n_i,
  input  logic                                  [`FLOO_NUM_ROUTES-1:0]  valid_i,
  output logic                                  [`FLOO_NUM_ROUTES-1:0]  ready_o,
  input  floo_red_pkg::flit_t                   [`FLOO_NUM_ROUTES-1:0]  data_i,
  input  logic                 [`FLOO_ID_W-1:0]                         node_id_i,
  output logic                                                          valid_o,
  input  logic                                                          ready_i,
  output floo_red_pkg::flit_t                                           data_o
);

  logic                arb_valid;
  logic                arb_ready;
  floo_red_pkg::flit_t arb_data;

  // Path selection and arbitration for all input routes.
  floo_output_arbiter u_output_arbiter (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .valid_i   ( valid_i   ),
    .ready_o   ( ready_o   ),
    .data_i    ( data_i    ),
    .node_id_i ( node_id_i ),
    .valid_o   ( arb_valid ),
    .ready_i   ( arb_ready ),
    .data_o    ( arb_data  )
  );

  // Registered stage towards the next hop.
  floo_out_spill u_out_spill (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .valid_i ( arb_valid ),
    .ready_o ( arb_ready ),
    .data_i  ( arb_data  ),
    .valid_o ( valid_o   ),
    .ready_i ( ready_i   ),
    .data_o  ( data_o    )
  );

endmodule

// File: source/floo_red_pkg.sv
// Flit layout is fixed at 48 bits for four routes; only single-flit reduction operands exist.
`include "floo_red_consts.svh"

package floo_red_pkg;

  // Operation applied to the payloads of all operands of one reduction.
  // Payloads are treated as unsigned values, also for the maximum.
  typedef enum logic [1:0] {
    RED_ADD = 2'd0,
    RED_MAX = 2'd1,
    RED_AND = 2'd2,
    RED_OR  = 2'd3
  } red_op_e;

  // Lock state of the wormhole arbiter.
  // In WH_LOCKED the granted route keeps the output until its tail flit.
  typedef enum logic {
    WH_IDLE   = 1'b0,
    WH_LOCKED = 1'b1
  } wh_state_e;

  // One flit as it travels between router ports.
  // A single-flit packet has last set on its only flit.
  typedef struct packed {
    // Marks the tail flit of a packet.
    logic                      last;
    // Sends the flit onto the reduction path.
    logic                      reduce;
    // Opcode of the reduction, only meaningful with reduce set.
    red_op_e                   red_op;
    // Routes whose flits are combined into one result.
    logic [`FLOO_MASK_W-1:0]   red_mask;
    // Source and destination node identifiers.
    logic [`FLOO_ID_W-1:0]     src_id;
    logic [`FLOO_ID_W-1:0]     dst_id;
    // Data carried by the flit.
    logic [`FLOO_DATA_W-1:0]   payload;
  } flit_t;

endpackage

// File: source/floo_reduction_arbiter.sv
// Combinational reduction; NumRoutes must not exceed FLOO_MASK_W and opcodes are not cross-checked.
`include "floo_red_consts.svh"

module floo_reduction_arbiter #(
  parameter int unsigned NumRoutes = `FLOO_NUM_ROUTES
) (
  input  logic                                  [NumRoutes-1:0]  valid_i,
  output logic                                  [NumRoutes-1:0]  ready_o,
  input  floo_red_pkg::flit_t                   [NumRoutes-1:0]  data_i,
  input  logic                 [`FLOO_ID_W-1:0]                  node_id_i,
  output logic                                                   valid_o,
  input  logic                                                   ready_i,
  output floo_red_pkg::flit_t                                    data_o
);

  localparam int unsigned IdxW = (NumRoutes > 1) ? $clog2(NumRoutes) : 1;

  logic [IdxW-1:0]          leader_idx;
  logic                     leader_found;
  floo_red_pkg::flit_t      leader;
  logic [NumRoutes-1:0]     op_mask;
  logic                     operands_ready;
  logic [`FLOO_DATA_W-1:0]  acc;

  // The lowest valid reducing route leads the reduction.
  always_comb begin
    leader_idx   = '0;
    leader_found = 1'b0;
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      if (!leader_found && valid_i[i]) begin
        leader_idx   = IdxW'(i);
        leader_found = 1'b1;
      end
    end
  end

  assign leader = data_i[leader_idx];

  always_comb begin
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      op_mask[i] = leader.red_mask[i];
    end
  end

  // Every route named by the leader must offer a reducing flit.
  assign operands_ready = leader_found && (op_mask != '0) && (&(valid_i | ~op_mask));

  // Fold the payloads of all named operands with the leader's opcode.
  always_comb begin
    if (leader.red_op == floo_red_pkg::RED_AND) begin
      acc = '1;
    end else begin
      acc = '0;
    end
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      if (op_mask[i]) begin
        case (leader.red_op)
          floo_red_pkg::RED_ADD: acc = acc + data_i[i].payload;
          floo_red_pkg::RED_MAX: acc = (data_i[i].payload > acc) ? data_i[i].payload : acc;
          floo_red_pkg::RED_AND: acc = acc & data_i[i].payload;
          floo_red_pkg::RED_OR:  acc = acc | data_i[i].payload;
        endcase
      end
    end
  end

  // The result is a single-flit packet from this node to the leader's destination.
  always_comb begin
    data_o          = leader;
    data_o.last     = 1'b1;
    data_o.reduce   = 1'b0;
    data_o.red_mask = '0;
    data_o.src_id   = node_id_i;
    data_o.payload  = acc;
  end

  assign valid_o = operands_ready;

  // All operands are consumed together on the one output transfer.
  assign ready_o = op_mask & {NumRoutes{valid_o & ready_i}};

endmodule

// File: source/floo_wormhole_arbiter.sv
// Round-robin wormhole arbiter; a granted route keeps the output until its tail flit transfers.
`include "floo_red_consts.svh"

module floo_wormhole_arbiter #(
  parameter int unsigned NumRoutes = `FLOO_NUM_ROUTES
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                 [NumRoutes-1:0]  valid_i,
  output logic                 [NumRoutes-1:0]  ready_o,
  input  floo_red_pkg::flit_t  [NumRoutes-1:0]  data_i,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output floo_red_pkg::flit_t                   data_o
);

  localparam int unsigned IdxW = (NumRoutes > 1) ? $clog2(NumRoutes) : 1;

  floo_red_pkg::wh_state_e state_q, state_d;
  logic [IdxW-1:0]         rr_ptr_q, rr_ptr_d;
  logic [IdxW-1:0]         lock_idx_q, lock_idx_d;
  logic [IdxW-1:0]         sel_idx;
  logic                    sel_found;
  logic                    xfer;

  // Search for a valid route starting at the round-robin pointer.
  // A locked grant overrides the search until the tail flit is gone.
  always_comb begin
    int unsigned idx;
    sel_idx   = rr_ptr_q;
    sel_found = 1'b0;
    for (int unsigned i = 0; i < NumRoutes; i++) begin
      idx = (rr_ptr_q + i) % NumRoutes;
      if (!sel_found && valid_i[idx]) begin
        sel_idx   = IdxW'(idx);
        sel_found = 1'b1;
      end
    end
    if (state_q == floo_red_pkg::WH_LOCKED) begin
      sel_idx   = lock_idx_q;
      sel_found = valid_i[lock_idx_q];
    end
  end

  assign valid_o = sel_found;
  assign data_o  = data_i[sel_idx];
  assign xfer    = sel_found & ready_i;

  always_comb begin
    ready_o          = '0;
    ready_o[sel_idx] = xfer;
  end

  // A head flit without last takes the lock, a tail flit releases it.
  // The pointer moves past the route that just finished a packet.
  always_comb begin
    state_d    = state_q;
    rr_ptr_d   = rr_ptr_q;
    lock_idx_d = lock_idx_q;
    if (xfer) begin
      if (data_o.last) begin
        state_d  = floo_red_pkg::WH_IDLE;
        rr_ptr_d = (sel_idx == IdxW'(NumRoutes - 1)) ? '0 : sel_idx + 1'b1;
      end else begin
        state_d    = floo_red_pkg::WH_LOCKED;
        lock_idx_d = sel_idx;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= floo_red_pkg::WH_IDLE;
      rr_ptr_q   <= '0;
      lock_idx_q <= '0;
    end else begin
      state_q    <= state_d;
      rr_ptr_q   <= rr_ptr_d;
      lock_idx_q <= lock_idx_d;
    end
  end

endmodule
